//--- hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // address layout: offset | index | tag, upper 16 bits not stored
    localparam int OFFSET_BITS  = 3;
    localparam int INDEX_BITS   = 5;
    localparam int TAG_BITS     = 8;
    localparam int LINES        = 2 ** INDEX_BITS;

    localparam int MEM_TAG_BITS = 4; // 0 means no transaction

    typedef enum logic [1:0] {
        BUS_NONE = 2'b00,
        BUS_LOAD = 2'b01
    } bus_command_e;

    // one fetch lane
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        bus_command_e command;
        logic [31:0]  addr;     // line aligned
    } mem_req_t;

    typedef struct packed {
        logic [MEM_TAG_BITS-1:0] accept_tag; // same cycle as the request
        logic [MEM_TAG_BITS-1:0] data_tag;   // names the returning line
        logic [63:0]             data;
    } mem_rsp_t;

    // line write from the miss controller
    typedef struct packed {
        logic                  we;
        logic [INDEX_BITS-1:0] index;
        logic [TAG_BITS-1:0]   tag;
        logic [63:0]           data;
    } fill_t;

endpackage

`default_nettype wire

//--- hdl/icache_array.sv
`default_nettype none

module icache_array #(
    parameter int FETCH_WIDTH = 2
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  icache_pkg::fetch_req_t [FETCH_WIDTH-1:0] fetch_req,
    input  icache_pkg::fill_t                       fill,
    output logic [FETCH_WIDTH-1:0]                  hit,
    output logic [FETCH_WIDTH-1:0][63:0]            hit_data
);
    import icache_pkg::*;

    logic [LINES-1:0]    valid_q;
    logic [TAG_BITS-1:0] tag_mem  [LINES];
    logic [63:0]         data_mem [LINES];

    logic [FETCH_WIDTH-1:0][INDEX_BITS-1:0] lane_index;
    logic [FETCH_WIDTH-1:0][TAG_BITS-1:0]   lane_tag;

    // per-lane lookup, purely combinational
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_index[i] = fetch_req[i].addr[OFFSET_BITS +: INDEX_BITS];
            lane_tag[i]   = fetch_req[i].addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
            hit[i]        = fetch_req[i].en && valid_q[lane_index[i]]
                            && (tag_mem[lane_index[i]] == lane_tag[i]);
            hit_data[i]   = data_mem[lane_index[i]];
        end
    end

    // valid bits come up cleared so every lane misses after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill.we) begin
            valid_q[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill.we) begin
            tag_mem[fill.index]  <= fill.tag;
            data_mem[fill.index] <= fill.data; // visible to lookup next cycle
        end
    end

    // miss controller must stay quiet while reset is held
    a_no_fill_in_reset: assert property (
        @(posedge clock) reset |-> !fill.we
    ) else $error("fill write during reset");

endmodule

`default_nettype wire

//--- hdl/icache_miss_ctrl.sv
`default_nettype none

module icache_miss_ctrl #(
    parameter int FETCH_WIDTH = 2
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  icache_pkg::fetch_req_t [FETCH_WIDTH-1:0] fetch_req,
    input  logic [FETCH_WIDTH-1:0]                  hit,
    input  icache_pkg::mem_rsp_t                    mem_rsp,
    output icache_pkg::mem_req_t                    mem_req,
    output icache_pkg::fill_t                       fill
);
    import icache_pkg::*;

    logic [FETCH_WIDTH-1:0]  miss;
    logic [31:0]             miss_addr;
    logic [INDEX_BITS-1:0]   miss_index;
    logic [TAG_BITS-1:0]     miss_tag;
    logic                    waiting;
    logic                    accepted;
    logic                    data_match;

    logic [MEM_TAG_BITS-1:0] mem_tag_q;   // outstanding transaction, 0 when idle
    logic [INDEX_BITS-1:0]   index_q;
    logic [TAG_BITS-1:0]     tag_q;

    assign miss    = ~hit & get_en(fetch_req);
    assign waiting = (mem_tag_q != '0);

    function automatic logic [FETCH_WIDTH-1:0] get_en(
        input fetch_req_t [FETCH_WIDTH-1:0] req
    );
        logic [FETCH_WIDTH-1:0] en;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            en[i] = req[i].en;
        end
        return en;
    endfunction

    // lowest-numbered missing lane wins
    always_comb begin
        miss_addr = '0;
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (miss[i]) begin
                miss_addr = fetch_req[i].addr;
            end
        end
    end

    assign miss_index = miss_addr[OFFSET_BITS +: INDEX_BITS];
    assign miss_tag   = miss_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];

    always_comb begin
        mem_req.command = (!waiting && (|miss)) ? BUS_LOAD : BUS_NONE;
        mem_req.addr    = {miss_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    end

    // nonzero accept tag in the request cycle, otherwise retried next cycle
    assign accepted   = (mem_req.command == BUS_LOAD) && (mem_rsp.accept_tag != '0);
    assign data_match = waiting && (mem_rsp.data_tag == mem_tag_q);

    always_comb begin
        fill.we    = data_match;
        fill.index = index_q;
        fill.tag   = tag_q;
        fill.data  = mem_rsp.data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_tag_q <= '0;
        end else if (accepted) begin
            mem_tag_q <= mem_rsp.accept_tag;
        end else if (data_match) begin
            mem_tag_q <= '0; // free for a new load next cycle
        end
    end

    always_ff @(posedge clock) begin
        if (accepted) begin
            index_q <= miss_index;
            tag_q   <= miss_tag;
        end
    end

    // accepted load blocks further loads until its line returns
    a_single_outstanding: assert property (
        @(posedge clock) disable iff (reset)
        accepted |=> (mem_req.command == BUS_NONE)
    ) else $error("load issued right after an accepted load");

    // a fill needs a tag recorded by an earlier acceptance
    a_fill_has_tag: assert property (
        @(posedge clock) disable iff (reset)
        fill.we |-> $past(accepted || waiting)
    ) else $error("fill without a recorded transaction");

endmodule

`default_nettype wire

//--- hdl/icache_fill_merge.sv
`default_nettype none

module icache_fill_merge #(
    parameter int FETCH_WIDTH = 2
) (
    input  icache_pkg::fetch_req_t [FETCH_WIDTH-1:0] fetch_req,
    input  logic [FETCH_WIDTH-1:0]                  hit,
    input  logic [FETCH_WIDTH-1:0][63:0]            hit_data,
    input  icache_pkg::fill_t                       fill,
    output icache_pkg::fetch_rsp_t [FETCH_WIDTH-1:0] fetch_rsp
);
    import icache_pkg::*;

    logic [FETCH_WIDTH-1:0] fill_match;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            // returning line matches this lane's index and tag
            fill_match[i] = fill.we && fetch_req[i].en
                && (fetch_req[i].addr[OFFSET_BITS +: INDEX_BITS] == fill.index)
                && (fetch_req[i].addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS] == fill.tag);

            fetch_rsp[i].valid = hit[i] || fill_match[i];
            fetch_rsp[i].data  = fill_match[i] ? fill.data : hit_data[i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
`default_nettype none

module icache_top #(
    parameter int FETCH_WIDTH = 2
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  icache_pkg::fetch_req_t [FETCH_WIDTH-1:0] fetch_req,
    output icache_pkg::fetch_rsp_t [FETCH_WIDTH-1:0] fetch_rsp,
    output icache_pkg::mem_req_t                    mem_req,
    input  icache_pkg::mem_rsp_t                    mem_rsp
);
    import icache_pkg::*;

    logic [FETCH_WIDTH-1:0]       hit;
    logic [FETCH_WIDTH-1:0][63:0] hit_data;
    fill_t                        fill;

    // tag/data lookup for all lanes
    icache_array #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) i_array (
        .clock     (clock),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fill      (fill),
        .hit       (hit),
        .hit_data  (hit_data)
    );

    // one outstanding line load at a time
    icache_miss_ctrl #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) i_miss_ctrl (
        .clock     (clock),
        .reset     (reset),
        .fetch_req (fetch_req),
        .hit       (hit),
        .mem_rsp   (mem_rsp),
        .mem_req   (mem_req),
        .fill      (fill)
    );

    icache_fill_merge #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) i_fill_merge (
        .fetch_req (fetch_req),
        .hit       (hit),
        .hit_data  (hit_data),
        .fill      (fill),
        .fetch_rsp (fetch_rsp)   // hits plus same-cycle forwarding
    );

endmodule

`default_nettype wire

//--- dv/icache_mem_model.sv
`default_nettype none

module icache_mem_model (
    input  logic                 clock,
    input  logic                 reset,
    input  icache_pkg::mem_req_t mem_req,
    input  logic [31:0]          rand_word,
    output icache_pkg::mem_rsp_t mem_rsp
);
    import icache_pkg::*;

    logic                    load;
    logic                    reject;
    logic                    pending;
    logic [3:0]              wait_cnt;
    logic [MEM_TAG_BITS-1:0] next_tag;    // rotates through 1..15
    logic [MEM_TAG_BITS-1:0] pend_tag;
    logic [31:0]             pend_addr;
    logic [MEM_TAG_BITS-1:0] data_tag_q;
    logic [63:0]             data_q;

    // line contents are a fixed hash of the line address
    function automatic logic [63:0] line_hash(input logic [31:0] a);
        return {a ^ 32'hc3a5_9e37, a * 32'h0019_660d + 32'h3c6e_f35f};
    endfunction

    assign load   = (mem_req.command == BUS_LOAD);
    assign reject = (rand_word[1:0] == 2'b00); // about one in four

    always_comb begin
        mem_rsp.accept_tag = (load && !reject) ? next_tag : '0;
        mem_rsp.data_tag   = data_tag_q;
        mem_rsp.data       = data_q;
    end

    always_ff @(posedge clock) begin
        data_tag_q <= '0; // data beat lasts one cycle
        if (reset) begin
            pending  <= 1'b0;
            next_tag <= 4'd1;
            data_q   <= '0;
        end else begin
            if (pending) begin
                if (wait_cnt == 4'd1) begin
                    data_tag_q <= pend_tag;
                    data_q     <= line_hash(pend_addr);
                    pending    <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 4'd1;
                end
            end
            if (load && !reject) begin
                pending   <= 1'b1;
                wait_cnt  <= {1'b0, rand_word[4:2]} + 4'd1; // line returns 2 to 9 cycles later
                pend_tag  <= next_tag;
                pend_addr <= mem_req.addr;
                next_tag  <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/icache_tb.sv
`default_nettype none

module icache_tb #(
    parameter int FETCH_WIDTH = 2
);
    import icache_pkg::*;

    localparam int CLOCK_PERIOD  = 20;
    localparam int NUM_REQS      = 400;
    localparam int WATCHDOG_TIME = NUM_REQS * 20 * CLOCK_PERIOD;

    logic                         clock;
    logic                         reset;
    fetch_req_t [FETCH_WIDTH-1:0] fetch_req;
    fetch_rsp_t [FETCH_WIDTH-1:0] fetch_rsp;
    mem_req_t                     mem_req;
    mem_rsp_t                     mem_rsp;
    logic [31:0]                  mem_rand;

    // reference tag store and the one outstanding load
    logic                    ref_valid [LINES];
    logic [TAG_BITS-1:0]     ref_tag   [LINES];
    logic                    out_busy;
    logic [MEM_TAG_BITS-1:0] out_tag;
    logic [31:0]             out_line;
    logic [FETCH_WIDTH-1:0]  lane_done;
    logic [31:0]             rng_state;
    logic                    timed_out;
    int                      error_count;
    int                      check_count;
    int                      completed;

    icache_top #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) i_dut (
        .clock     (clock),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    icache_mem_model i_mem (
        .clock     (clock),
        .reset     (reset),
        .mem_req   (mem_req),
        .rand_word (mem_rand),
        .mem_rsp   (mem_rsp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic logic [63:0] line_hash(input logic [31:0] a);
        return {a ^ 32'hc3a5_9e37, a * 32'h0019_660d + 32'h3c6e_f35f};
    endfunction

    // 40 lines, indices 0..7 come with two tags
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        logic [31:0] k;
        logic [7:0]  tag;
        k   = {8'h00, r[23:0]} % 32'd40;
        tag = (k < 32'd32) ? 8'h0d : 8'h5e;
        return {16'h0000, tag, k[4:0], r[26:24]};
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift(rng_state);
        r = rng_state;
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s: actual %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_cycle();
        logic [FETCH_WIDTH-1:0] exp_valid;
        logic                   fill_now;
        logic                   found;
        logic [31:0]            exp_addr;
        logic [31:0]            line;
        logic [INDEX_BITS-1:0]  idx;
        fill_now = out_busy && (mem_rsp.data_tag == out_tag);
        found    = 1'b0;
        exp_addr = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            line = line_of(fetch_req[i].addr);
            idx  = line[OFFSET_BITS +: INDEX_BITS];
            exp_valid[i] = fetch_req[i].en
                && ((ref_valid[idx] && ref_tag[idx] == line[15:8])
                    || (fill_now && line == out_line)); // forwarded in the fill cycle
            check_value($sformatf("fetch_rsp[%0d].valid", i),
                        64'(fetch_rsp[i].valid), 64'(exp_valid[i]));
            if (exp_valid[i]) begin
                check_value($sformatf("fetch_rsp[%0d].data", i),
                            fetch_rsp[i].data, line_hash(line));
            end
            if (fetch_req[i].en && !exp_valid[i] && !found) begin
                found    = 1'b1; // lowest missing lane
                exp_addr = line;
            end
            lane_done[i] = fetch_req[i].en && fetch_rsp[i].valid;
            if (lane_done[i]) begin
                completed++;
            end
        end
        check_value("mem_req.command", 64'(mem_req.command),
                    64'((found && !out_busy) ? BUS_LOAD : BUS_NONE));
        if (found && !out_busy) begin
            check_value("mem_req.addr", 64'(mem_req.addr), 64'(exp_addr));
            if (mem_rsp.accept_tag != '0) begin
                out_busy = 1'b1;
                out_tag  = mem_rsp.accept_tag;
                out_line = exp_addr;
            end
        end else if (fill_now) begin
            ref_valid[out_line[7:3]] = 1'b1;
            ref_tag[out_line[7:3]]   = out_line[15:8];
            out_busy                 = 1'b0;
        end
    endtask

    task automatic drive_lanes();
        fetch_req_t [FETCH_WIDTH-1:0] next_req;
        logic [31:0]                  r;
        next_req = fetch_req;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (lane_done[i] || !fetch_req[i].en) begin // pending lanes hold their address
                draw_random(r);
                next_req[i].en   = (r[31:30] != 2'b00);
                next_req[i].addr = pick_addr(r);
            end
        end
        draw_random(r);
        fetch_req <= next_req;
        mem_rand  <= r;
    endtask

    task automatic report_and_finish();
        $display("checks %0d, errors %0d, requests completed %0d of %0d",
                 check_count, error_count, completed, NUM_REQS);
        if (error_count == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before all fetch requests were answered");
        timed_out = 1'b1;
        report_and_finish();
    end

    initial begin
        error_count = 0;
        check_count = 0;
        completed   = 0;
        timed_out   = 1'b0;
        rng_state   = 32'd1447;
        out_busy    = 1'b0;
        out_tag     = '0;
        out_line    = '0;
        lane_done   = '0;
        for (int i = 0; i < LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        reset     = 1'b1;
        fetch_req = '0;
        mem_rand  = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("mem_req.command", 64'(mem_req.command), 64'(BUS_NONE));
        check_cycle();
        while (completed < NUM_REQS) begin
            @(posedge clock);
            drive_lanes();
            @(negedge clock);
            check_cycle();
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- project.f
hdl/icache_pkg.sv
hdl/icache_array.sv
hdl/icache_miss_ctrl.sv
hdl/icache_fill_merge.sv
hdl/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= icache_tb
WIDTHS    ?= 2 3
BUILD_DIR ?= build
FILELIST  ?= project.f
FAIL_MSG  ?= Simulation failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINS    := $(foreach w,$(WIDTHS),$(BUILD_DIR)/w$(w)/V$(TOP))

.PHONY: all build run clean

all: run

build: $(BINS)

# one binary per fetch width, rebuilt only when a source changes
$(BUILD_DIR)/w%/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GFETCH_WIDTH=$* --Mdir $(BUILD_DIR)/w$*

run: $(BINS)
	@status=0; \
	for w in $(WIDTHS); do \
		log=$(BUILD_DIR)/sim_w$$w.log; \
		$(BUILD_DIR)/w$$w/V$(TOP) > $$log 2>&1 || status=1; \
		cat $$log; \
		if grep -q "$(FAIL_MSG)" $$log; then status=1; fi; \
	done; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR)
